// ==== lane_mgmt_pkg.sv ====
package lane_mgmt_pkg;

  // lane and beat geometry
  localparam int MAX_LANES   = 4;
  localparam int BEAT_BYTES  = 4;
  localparam int BLOCK_WORDS = 4;
  localparam int BLOCK_CNT_W = $clog2(BLOCK_WORDS);

  // ordered-set beats carry one 32-bit word per lane
  localparam int DL_DATA_W = BEAT_BYTES * 8;
  localparam int OS_DATA_W = MAX_LANES * DL_DATA_W;
  localparam int OS_K_W    = MAX_LANES * BEAT_BYTES;

  localparam logic [2:0] PIPE_BYTES_GEN12 = 3'd2;
  localparam logic [2:0] PIPE_BYTES_GEN3  = 3'd4;

  localparam logic [7:0] PAD_GEN12 = 8'h00;
  localparam logic [7:0] PAD_GEN3  = 8'hF7;

  // 128b/130b sync header values
  localparam logic [1:0] SYNC_OS   = 2'b10;
  localparam logic [1:0] SYNC_DATA = 2'b01;

  localparam logic [BLOCK_CNT_W-1:0] BLOCK_LAST = BLOCK_CNT_W'(BLOCK_WORDS - 1);

  typedef enum logic [1:0] {GEN1, GEN2, GEN3} rate_e;

  typedef enum logic [1:0] {X1, X2, X4} lane_cnt_e;

  typedef enum logic [1:0] {ST_IDLE, ST_TX_OS, ST_TX_DATA} mgmt_state_e;

  typedef struct packed {
    logic [2:0]           pipe_bytes;
    logic [MAX_LANES-1:0] lane_mask;
    logic [7:0]           pad;
    logic                 is_gen3;
  } lane_cfg_t;

  // data slots use sym[0] only, ordered-set slots one byte per lane
  typedef struct packed {
    logic                      valid;
    logic                      is_os;
    logic                      last;
    logic [MAX_LANES-1:0][7:0] sym;
    logic [MAX_LANES-1:0]      k;
  } sym_slot_t;

  typedef struct packed {
    logic [MAX_LANES-1:0]                   valid;
    logic [MAX_LANES-1:0][DL_DATA_W-1:0]    data;
    logic [MAX_LANES-1:0][BEAT_BYTES-1:0]   k;
    logic                                   is_os;
  } pipe_word_t;

endpackage

// ==== lane_rate_cfg.sv ====
`timescale 1ns/1ps

module lane_rate_cfg (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  lane_mgmt_pkg::rate_e     rate_i,
  input  lane_mgmt_pkg::lane_cnt_e lanes_i,
  input  logic                     busy_i,
  output lane_mgmt_pkg::lane_cfg_t cfg_o,
  output logic [5:0]               pipe_width_o
);

  lane_mgmt_pkg::rate_e     rate_q;
  lane_mgmt_pkg::lane_cnt_e lanes_q;

  // settings only move between packets
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rate_q  <= lane_mgmt_pkg::GEN1;
      lanes_q <= lane_mgmt_pkg::X1;
    end else if (!busy_i) begin
      rate_q  <= rate_i;
      lanes_q <= lanes_i;
    end
  end

  always_comb begin
    cfg_o.is_gen3 = (rate_q == lane_mgmt_pkg::GEN3);
    if (cfg_o.is_gen3) begin
      cfg_o.pipe_bytes = lane_mgmt_pkg::PIPE_BYTES_GEN3;
      cfg_o.pad        = lane_mgmt_pkg::PAD_GEN3;
    end else begin
      cfg_o.pipe_bytes = lane_mgmt_pkg::PIPE_BYTES_GEN12;
      cfg_o.pad        = lane_mgmt_pkg::PAD_GEN12;
    end
    case (lanes_q)
      lane_mgmt_pkg::X2: cfg_o.lane_mask = 4'b0011;
      lane_mgmt_pkg::X4: cfg_o.lane_mask = 4'b1111;
      default:           cfg_o.lane_mask = 4'b0001;
    endcase
  end

  // width in bits is bytes times eight
  assign pipe_width_o = {cfg_o.pipe_bytes, 3'b000};

endmodule

// ==== lane_byte_serializer.sv ====
`timescale 1ns/1ps

module lane_byte_serializer (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  lane_mgmt_pkg::lane_cfg_t               cfg_i,
  input  logic [lane_mgmt_pkg::OS_DATA_W-1:0]    os_tdata_i,
  input  logic [lane_mgmt_pkg::OS_K_W-1:0]       os_tuser_i,
  input  logic                                   os_tvalid_i,
  input  logic                                   os_tlast_i,
  output logic                                   os_tready_o,
  input  logic [lane_mgmt_pkg::DL_DATA_W-1:0]    dl_tdata_i,
  input  logic [lane_mgmt_pkg::BEAT_BYTES-1:0]   dl_tuser_i,
  input  logic                                   dl_tvalid_i,
  input  logic                                   dl_tlast_i,
  output logic                                   dl_tready_o,
  output logic                                   busy_o,
  output lane_mgmt_pkg::sym_slot_t               slot_o
);

  lane_mgmt_pkg::mgmt_state_e            state_q;
  logic [lane_mgmt_pkg::OS_DATA_W-1:0]   beat_q;
  logic [lane_mgmt_pkg::OS_K_W-1:0]      beat_k_q;
  logic                                  beat_last_q;
  logic                                  full_q;
  logic [1:0]                            idx_q;
  logic [1:0]                            final_idx;
  logic                                  is_os_st;
  logic                                  end_of_beat;
  logic                                  take;
  logic                                  accept;
  lane_mgmt_pkg::sym_slot_t              slot_d;

  assign is_os_st = (state_q == lane_mgmt_pkg::ST_TX_OS);

  // ordered sets give P slots per beat, data always four
  assign final_idx   = is_os_st ? (cfg_i.pipe_bytes[1:0] - 2'd1) : 2'(lane_mgmt_pkg::BEAT_BYTES - 1);
  assign end_of_beat = full_q && (idx_q == final_idx);

  // no new beat behind a tlast beat, the next packet starts from idle
  assign take        = !full_q || (end_of_beat && !beat_last_q);
  assign os_tready_o = is_os_st && take;
  assign dl_tready_o = (state_q == lane_mgmt_pkg::ST_TX_DATA) && take;
  assign accept      = (os_tready_o && os_tvalid_i) || (dl_tready_o && dl_tvalid_i);

  assign busy_o = (state_q != lane_mgmt_pkg::ST_IDLE) || slot_o.valid;

  always_comb begin
    slot_d       = '0;
    slot_d.valid = full_q;
    slot_d.is_os = is_os_st;
    slot_d.last  = end_of_beat && beat_last_q;
    if (is_os_st) begin
      for (int l = 0; l < lane_mgmt_pkg::MAX_LANES; l++) begin
        slot_d.sym[l] = beat_q[32*l + 8*idx_q +: 8];
        slot_d.k[l]   = beat_k_q[4*l + idx_q];
      end
    end else begin
      slot_d.sym[0] = beat_q[8*idx_q +: 8];
      slot_d.k[0]   = beat_k_q[idx_q];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= lane_mgmt_pkg::ST_IDLE;
      full_q      <= 1'b0;
      beat_last_q <= 1'b0;
      idx_q       <= '0;
      slot_o      <= '0;
    end else begin
      slot_o <= slot_d;
      if (full_q) begin
        idx_q <= end_of_beat ? 2'd0 : idx_q + 2'd1;
      end
      if (accept) begin
        full_q      <= 1'b1;
        idx_q       <= '0;
        beat_last_q <= is_os_st ? os_tlast_i : dl_tlast_i;
      end else if (end_of_beat) begin
        full_q <= 1'b0;
      end
      case (state_q)
        lane_mgmt_pkg::ST_IDLE: begin
          // wait for the previous tail slot so the config can update
          if (!slot_o.valid) begin
            if (os_tvalid_i) begin
              state_q <= lane_mgmt_pkg::ST_TX_OS;
            end else if (dl_tvalid_i) begin
              state_q <= lane_mgmt_pkg::ST_TX_DATA;
            end
          end
        end
        default: begin
          if (end_of_beat && beat_last_q) begin
            state_q <= lane_mgmt_pkg::ST_IDLE;
          end
        end
      endcase
    end
  end

  // beat payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (is_os_st) begin
        beat_q   <= os_tdata_i;
        beat_k_q <= os_tuser_i;
      end else begin
        beat_q[lane_mgmt_pkg::DL_DATA_W-1:0]    <= dl_tdata_i;
        beat_k_q[lane_mgmt_pkg::BEAT_BYTES-1:0] <= dl_tuser_i;
      end
    end
  end

endmodule

// ==== lane_striper.sv ====
`timescale 1ns/1ps

module lane_striper (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  lane_mgmt_pkg::lane_cfg_t  cfg_i,
  input  lane_mgmt_pkg::sym_slot_t  slot_i,
  output lane_mgmt_pkg::pipe_word_t word_o
);

  localparam int NL = lane_mgmt_pkg::MAX_LANES;
  localparam int NB = lane_mgmt_pkg::BEAT_BYTES;

  logic [NL-1:0][lane_mgmt_pkg::DL_DATA_W-1:0] buf_q;
  logic [NL-1:0][NB-1:0]                       bufk_q;
  logic [NL-1:0][lane_mgmt_pkg::DL_DATA_W-1:0] fill_data;
  logic [NL-1:0][NB-1:0]                       fill_k;
  logic                                        fresh_q;
  logic [1:0]                                  cur_q;
  logic [1:0]                                  pos_q;
  logic [1:0]                                  cur_d;
  logic [1:0]                                  pos_d;
  logic [1:0]                                  last_lane;
  logic [1:0]                                  last_pos;
  logic                                        wrap_pos;
  logic                                        lane_end;
  logic                                        complete;

  // lane masks are contiguous from lane 0
  always_comb begin
    if (cfg_i.lane_mask[3]) begin
      last_lane = 2'd3;
    end else if (cfg_i.lane_mask[1]) begin
      last_lane = 2'd1;
    end else begin
      last_lane = 2'd0;
    end
  end

  assign last_pos = cfg_i.pipe_bytes[1:0] - 2'd1;
  assign wrap_pos = (pos_q == last_pos);
  assign lane_end = slot_i.is_os || (cur_q == last_lane);
  assign complete = slot_i.valid && (slot_i.last || (wrap_pos && lane_end));

  always_comb begin
    fill_data = buf_q;
    fill_k    = bufk_q;
    // a fresh word starts as all pad
    if (fresh_q) begin
      for (int l = 0; l < NL; l++) begin
        for (int b = 0; b < NB; b++) begin
          fill_data[l][8*b +: 8] = cfg_i.pad;
        end
      end
      fill_k = '0;
    end
    if (slot_i.valid) begin
      if (slot_i.is_os) begin
        for (int l = 0; l < NL; l++) begin
          if (cfg_i.lane_mask[l]) begin
            fill_data[l][8*pos_q +: 8] = slot_i.sym[l];
            fill_k[l][pos_q]           = slot_i.k[l];
          end
        end
      end else begin
        fill_data[cur_q][8*pos_q +: 8] = slot_i.sym[0];
        fill_k[cur_q][pos_q]           = slot_i.k[0];
      end
    end
  end

  // data walks lanes first, then symbol positions
  always_comb begin
    cur_d = cur_q;
    pos_d = pos_q;
    if (slot_i.valid) begin
      if (slot_i.last) begin
        cur_d = '0;
        pos_d = '0;
      end else if (lane_end) begin
        cur_d = '0;
        pos_d = wrap_pos ? 2'd0 : pos_q + 2'd1;
      end else begin
        cur_d = cur_q + 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fresh_q <= 1'b1;
      cur_q   <= '0;
      pos_q   <= '0;
      word_o  <= '0;
    end else begin
      cur_q        <= cur_d;
      pos_q        <= pos_d;
      word_o.valid <= complete ? cfg_i.lane_mask : '0;
      if (slot_i.valid) begin
        fresh_q <= complete;
      end
      if (complete) begin
        word_o.data  <= fill_data;
        word_o.k     <= fill_k;
        word_o.is_os <= slot_i.is_os;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (slot_i.valid) begin
      buf_q  <= fill_data;
      bufk_q <= fill_k;
    end
  end

endmodule

// ==== lane_block_framer.sv ====
`timescale 1ns/1ps

module lane_block_framer (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  lane_mgmt_pkg::lane_cfg_t                  cfg_i,
  input  lane_mgmt_pkg::pipe_word_t                 word_i,
  output logic [lane_mgmt_pkg::OS_DATA_W-1:0]       data_o,
  output logic [lane_mgmt_pkg::MAX_LANES-1:0]       data_valid_o,
  output logic [lane_mgmt_pkg::OS_K_W-1:0]          d_k_o,
  output logic [2*lane_mgmt_pkg::MAX_LANES-1:0]     sync_header_o,
  output logic [lane_mgmt_pkg::MAX_LANES-1:0]       start_block_o
);

  logic [lane_mgmt_pkg::BLOCK_CNT_W-1:0]   blk_cnt_q;
  logic                                    prev_os_q;
  logic                                    word_vld;
  logic                                    blk_first;
  logic [2*lane_mgmt_pkg::MAX_LANES-1:0]   hdr_d;

  assign word_vld = |word_i.valid;

  // a change of packet type opens a new block
  assign blk_first = (word_i.is_os != prev_os_q) || (blk_cnt_q == '0);

  always_comb begin
    hdr_d = '0;
    for (int l = 0; l < lane_mgmt_pkg::MAX_LANES; l++) begin
      if (word_i.valid[l]) begin
        hdr_d[2*l +: 2] = word_i.is_os ? lane_mgmt_pkg::SYNC_OS : lane_mgmt_pkg::SYNC_DATA;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      data_valid_o  <= '0;
      start_block_o <= '0;
      sync_header_o <= '0;
      blk_cnt_q     <= '0;
      prev_os_q     <= 1'b0;
    end else begin
      data_valid_o <= word_i.valid;
      if (!cfg_i.is_gen3) begin
        start_block_o <= '0;
        sync_header_o <= '0;
        blk_cnt_q     <= '0;
        prev_os_q     <= 1'b0;
      end else if (word_vld) begin
        prev_os_q     <= word_i.is_os;
        start_block_o <= blk_first ? word_i.valid : '0;
        if (blk_first) begin
          blk_cnt_q     <= lane_mgmt_pkg::BLOCK_CNT_W'(1);
          sync_header_o <= hdr_d;
        end else begin
          blk_cnt_q <= (blk_cnt_q == lane_mgmt_pkg::BLOCK_LAST) ? '0 : blk_cnt_q + 1'b1;
        end
      end else begin
        start_block_o <= '0;
      end
    end
  end

  // lane payload
  always_ff @(posedge clk_i) begin
    if (word_vld) begin
      data_o <= word_i.data;
      d_k_o  <= word_i.k;
    end
  end

endmodule

// ==== lane_mgmt_top.sv ====
`timescale 1ns/1ps

module lane_mgmt_top (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  // ordered-set stream, one word per lane
  input  logic [lane_mgmt_pkg::OS_DATA_W-1:0]     os_tdata_i,
  input  logic [lane_mgmt_pkg::OS_K_W-1:0]        os_tkeep_i,
  input  logic [lane_mgmt_pkg::OS_K_W-1:0]        os_tuser_i,
  input  logic                                    os_tlast_i,
  input  logic                                    os_tvalid_i,
  output logic                                    os_tready_o,
  // link-layer data stream
  input  logic [lane_mgmt_pkg::DL_DATA_W-1:0]     dl_tdata_i,
  input  logic [lane_mgmt_pkg::BEAT_BYTES-1:0]    dl_tkeep_i,
  input  logic [lane_mgmt_pkg::BEAT_BYTES-1:0]    dl_tuser_i,
  input  logic                                    dl_tlast_i,
  input  logic                                    dl_tvalid_i,
  output logic                                    dl_tready_o,
  input  lane_mgmt_pkg::rate_e                    rate_i,
  input  lane_mgmt_pkg::lane_cnt_e                lanes_i,
  // PIPE side
  output logic [lane_mgmt_pkg::OS_DATA_W-1:0]     data_o,
  output logic [lane_mgmt_pkg::MAX_LANES-1:0]     data_valid_o,
  output logic [lane_mgmt_pkg::OS_K_W-1:0]        d_k_o,
  output logic [2*lane_mgmt_pkg::MAX_LANES-1:0]   sync_header_o,
  output logic [lane_mgmt_pkg::MAX_LANES-1:0]     start_block_o,
  output logic [5:0]                              pipe_width_o
);

  // tkeep is accepted but every beat is treated as full
  lane_mgmt_pkg::lane_cfg_t  cfg;
  lane_mgmt_pkg::sym_slot_t  slot;
  lane_mgmt_pkg::pipe_word_t word;
  logic                      busy;

  lane_rate_cfg u_rate_cfg (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .rate_i       (rate_i),
    .lanes_i      (lanes_i),
    .busy_i       (busy),
    .cfg_o        (cfg),
    .pipe_width_o (pipe_width_o)
  );

  lane_byte_serializer u_serializer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_i       (cfg),
    .os_tdata_i  (os_tdata_i),
    .os_tuser_i  (os_tuser_i),
    .os_tvalid_i (os_tvalid_i),
    .os_tlast_i  (os_tlast_i),
    .os_tready_o (os_tready_o),
    .dl_tdata_i  (dl_tdata_i),
    .dl_tuser_i  (dl_tuser_i),
    .dl_tvalid_i (dl_tvalid_i),
    .dl_tlast_i  (dl_tlast_i),
    .dl_tready_o (dl_tready_o),
    .busy_o      (busy),
    .slot_o      (slot)
  );

  lane_striper u_striper (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .cfg_i   (cfg),
    .slot_i  (slot),
    .word_o  (word)
  );

  lane_block_framer u_framer (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .cfg_i         (cfg),
    .word_i        (word),
    .data_o        (data_o),
    .data_valid_o  (data_valid_o),
    .d_k_o         (d_k_o),
    .sync_header_o (sync_header_o),
    .start_block_o (start_block_o)
  );

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    // release on a falling edge after two rising edges
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

  always #10 clk_o = ~clk_o;

endmodule

// ==== lane_mgmt_asserts.sv ====
`timescale 1ns/1ps

module lane_mgmt_asserts (
  input logic         clk_i,
  input logic         rst_n_i,
  input logic         os_tvalid_i,
  input logic         os_tready_o,
  input logic         dl_tvalid_i,
  input logic         dl_tready_o,
  input logic [1:0]   lanes_i,
  input logic [127:0] data_o,
  input logic [3:0]   data_valid_o,
  input logic [15:0]  d_k_o,
  input logic [7:0]   sync_header_o,
  input logic [3:0]   start_block_o,
  input logic [5:0]   pipe_width_o
);

  int         fail_cnt = 0;
  logic [5:0] pw_q;
  logic [1:0] lanes_q;
  logic [1:0] m_cnt_q;
  logic       m_prev_os_q;
  logic       word_os;
  logic       first_exp;
  logic [3:0] mask_exp;
  logic       payload_ok;
  logic       k_ok;
  logic       k_exp;
  logic       hdr_ok;
  logic       seen_pad;
  logic [7:0] pad;
  logic [7:0] base;
  logic [7:0] v;
  int         n;
  int         p;

  // width that was in force when the current output word was registered
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pw_q        <= 6'd16;
      lanes_q     <= lane_mgmt_pkg::X1;
      m_cnt_q     <= 2'd0;
      m_prev_os_q <= 1'b0;
    end else begin
      pw_q <= pipe_width_o;
      // lane count of the packet whose beats were taken in last
      if ((os_tready_o && os_tvalid_i) || (dl_tready_o && dl_tvalid_i)) begin
        lanes_q <= lanes_i;
      end
      if (pw_q != 6'd32) begin
        m_cnt_q     <= 2'd0;
        m_prev_os_q <= 1'b0;
      end else if (|data_valid_o) begin
        m_prev_os_q <= word_os;
        m_cnt_q     <= first_exp ? 2'd1 : m_cnt_q + 2'd1;
      end
    end
  end

  always_comb begin
    n        = (lanes_q == lane_mgmt_pkg::X4) ? 4 : ((lanes_q == lane_mgmt_pkg::X2) ? 2 : 1);
    mask_exp = 4'((1 << n) - 1);
    p        = (pw_q == 6'd32) ? 4 : 2;
    pad      = (p == 4) ? 8'hF7 : 8'h00;
    base     = data_o[7:0];
    // ordered-set bytes start at 0x80, data bytes stay well below
    word_os   = (base >= 8'h80);
    first_exp = (word_os != m_prev_os_q) || (m_cnt_q == 2'd0);
    payload_ok = 1'b1;
    k_ok       = 1'b1;
    seen_pad   = 1'b0;
    for (int l = 0; l < 4; l++) begin
      for (int b = 0; b < 4; b++) begin
        v = data_o[32*l + 8*b +: 8];
        // K marks byte 0 of each ordered-set lane and every third data byte
        if (b >= p) begin
          k_exp = 1'b0;
        end else if (word_os) begin
          k_exp = (b == 0);
        end else begin
          k_exp = (v != pad) && (v % 8'd3 == 8'd0);
        end
        if (data_valid_o[l] && b >= p && v != pad) begin
          payload_ok = 1'b0;
        end
        if (data_valid_o[l] && b < p && word_os && v != 8'h80 + 8'(16*l + b)) begin
          payload_ok = 1'b0;
        end
        if (data_valid_o[l] && d_k_o[4*l + b] != k_exp) begin
          k_ok = 1'b0;
        end
      end
    end
    // data order is lane first, then position; pad only after the end
    if (!word_os) begin
      for (int i = 0; i < 16; i++) begin
        if (i < n * p) begin
          v = data_o[32*(i % n) + 8*(i / n) +: 8];
          if (v == pad) begin
            seen_pad = 1'b1;
          end else if (seen_pad || v != base + 8'(i)) begin
            payload_ok = 1'b0;
          end
        end
      end
    end
    // every lane carries the header on a block start, lane 0 holds it after
    hdr_ok = 1'b1;
    for (int l = 0; l < 4; l++) begin
      if (data_valid_o[l] && (first_exp || l == 0) &&
          sync_header_o[2*l +: 2] != (word_os ? 2'b10 : 2'b01)) begin
        hdr_ok = 1'b0;
      end
    end
  end

  assert property (@(posedge clk_i) !rst_n_i |-> (!os_tready_o && !dl_tready_o &&
      data_valid_o == 4'b0 && start_block_o == 4'b0 && sync_header_o == 8'b0 &&
      pipe_width_o == 6'd16))
  else begin
    fail_cnt++;
    $error("outputs not idle during reset");
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
      |data_valid_o |-> data_valid_o == mask_exp)
  else begin
    fail_cnt++;
    $error("data_valid_o does not match the active lanes");
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) |data_valid_o |-> payload_ok)
  else begin
    fail_cnt++;
    $error("lane byte placement or pad wrong");
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) |data_valid_o |-> k_ok)
  else begin
    fail_cnt++;
    $error("K flags do not follow their bytes");
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pw_q == 6'd16 |-> (sync_header_o == 8'b0 && start_block_o == 4'b0))
  else begin
    fail_cnt++;
    $error("sync header or start block active below gen3");
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (pw_q == 6'd32 && |data_valid_o) |->
      start_block_o == (first_exp ? data_valid_o : 4'b0))
  else begin
    fail_cnt++;
    $error("start block on wrong word");
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
      start_block_o != 4'b0 |-> start_block_o == data_valid_o)
  else begin
    fail_cnt++;
    $error("start block without matching valid");
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (pw_q == 6'd32 && |data_valid_o) |-> hdr_ok)
  else begin
    fail_cnt++;
    $error("sync header does not match word type");
  end

  // rate stays put while a packet is being taken in
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (os_tready_o || dl_tready_o) |=> $stable(pipe_width_o))
  else begin
    fail_cnt++;
    $error("rate changed inside a packet");
  end

endmodule

// ==== tb_lane_mgmt.sv ====
`timescale 1ns/1ps

module tb_lane_mgmt;

  localparam int NT = 14;

  logic                     clk_i;
  logic                     rst_n_i;
  logic [127:0]             os_tdata_i;
  logic [15:0]              os_tkeep_i;
  logic [15:0]              os_tuser_i;
  logic                     os_tlast_i;
  logic                     os_tvalid_i;
  logic                     os_tready_o;
  logic [31:0]              dl_tdata_i;
  logic [3:0]               dl_tkeep_i;
  logic [3:0]               dl_tuser_i;
  logic                     dl_tlast_i;
  logic                     dl_tvalid_i;
  logic                     dl_tready_o;
  lane_mgmt_pkg::rate_e     rate_i;
  lane_mgmt_pkg::lane_cnt_e lanes_i;
  logic [127:0]             data_o;
  logic [3:0]               data_valid_o;
  logic [15:0]              d_k_o;
  logic [7:0]               sync_header_o;
  logic [3:0]               start_block_o;
  logic [5:0]               pipe_width_o;

  // one entry per packet: rate, lane count, ordered set or data, beats
  int rate_c[NT]  = '{0, 0, 0, 0, 1, 2, 2, 2, 2, 2, 2, 1, 2, 0};
  int lanes_c[NT] = '{0, 1, 2, 2, 1, 0, 1, 2, 2, 2, 2, 2, 0, 0};
  int os_c[NT]    = '{0, 0, 0, 1, 1, 0, 0, 0, 1, 0, 0, 0, 1, 0};
  int beats_c[NT] = '{3, 5, 3, 2, 3, 5, 3, 6, 5, 9, 2, 4, 2, 2};
  // packet during which the rate input moves to gen3
  int mid_change_t = 11;

  int seed     = 53;
  int tb_errs  = 0;
  int cycles   = 0;
  int limit    = 100000;
  int total    = 0;

  tb_clkgen u_clkgen (
    .clk_o   (clk_i),
    .rst_n_o (rst_n_i)
  );

  lane_mgmt_top lane_mgmt_top_i (.*);

  bind lane_mgmt_top lane_mgmt_asserts u_asserts (.*);

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic idle_gap();
    int n;
    n = $unsigned($random(seed)) % 3;
    repeat (n) @(negedge clk_i);
  endtask

  task automatic check_width(input int rate);
    logic [5:0] exp;
    exp = (rate == 2) ? 6'd32 : 6'd16;
    if (pipe_width_o !== exp) begin
      $display("ERROR at %0t: pipe_width_o is %0d, expected %0d", $time, pipe_width_o, exp);
      tb_errs++;
    end
  endtask

  task automatic send_packet(input int t);
    logic ready;
    for (int b = 0; b < beats_c[t]; b++) begin
      if (os_c[t] != 0) begin
        for (int l = 0; l < 4; l++) begin
          for (int j = 0; j < 4; j++) begin
            os_tdata_i[32*l + 8*j +: 8] = 8'h80 + 8'(16*l + j);
          end
        end
        os_tlast_i  = (b == beats_c[t] - 1);
        os_tvalid_i = 1'b1;
      end else begin
        // K on every third data byte
        for (int j = 0; j < 4; j++) begin
          dl_tdata_i[8*j +: 8] = 8'(4*b + j + 1);
          dl_tuser_i[j]        = ((4*b + j + 1) % 3 == 0);
        end
        dl_tlast_i  = (b == beats_c[t] - 1);
        dl_tvalid_i = 1'b1;
      end
      // tready does not depend on tvalid, so its falling-edge value holds
      do begin
        ready = (os_c[t] != 0) ? os_tready_o : dl_tready_o;
        @(negedge clk_i);
      end while (!ready);
      os_tvalid_i = 1'b0;
      dl_tvalid_i = 1'b0;
      if (t == mid_change_t && b == 1) begin
        rate_i = lane_mgmt_pkg::GEN3;
      end
      if (b == beats_c[t] - 1) begin
        check_width(rate_c[t]);
      end
      idle_gap();
    end
  endtask

  initial begin
    os_tdata_i  = '0;
    os_tkeep_i  = '1;
    os_tuser_i  = 16'h1111;
    os_tlast_i  = 1'b0;
    os_tvalid_i = 1'b0;
    dl_tdata_i  = '0;
    dl_tkeep_i  = '1;
    dl_tuser_i  = '0;
    dl_tlast_i  = 1'b0;
    dl_tvalid_i = 1'b0;
    rate_i      = lane_mgmt_pkg::GEN1;
    lanes_i     = lane_mgmt_pkg::X1;
    for (int t = 0; t < NT; t++) begin
      total += beats_c[t] * ((os_c[t] != 0) ? 16 : 4);
    end
    limit = 4 * total + 200;
    @(posedge rst_n_i);
    @(negedge clk_i);
    for (int t = 0; t < NT; t++) begin
      rate_i  = lane_mgmt_pkg::rate_e'(rate_c[t]);
      lanes_i = lane_mgmt_pkg::lane_cnt_e'(lanes_c[t]);
      @(negedge clk_i);
      send_packet(t);
    end
    // let the last words leave the pipeline
    repeat (20) @(negedge clk_i);
    $display("errors: %0d value, %0d assertion", tb_errs, lane_mgmt_top_i.u_asserts.fail_cnt);
    if (tb_errs == 0 && lane_mgmt_top_i.u_asserts.fail_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
lane_mgmt_pkg.sv
lane_rate_cfg.sv
lane_byte_serializer.sv
lane_striper.sv
lane_block_framer.sv
lane_mgmt_top.sv
tb_clkgen.sv
lane_mgmt_asserts.sv
tb_lane_mgmt.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and log"

test:
	verilator --binary --timing --assert --top-module tb_lane_mgmt -f tb.f -o sim_tb
	./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 || echo "simulation exited with an error" >> sim.log
	@cat sim.log
	@if grep -q -e "STATUS: FAIL" -e "exited with an error" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
